//--- Makefile
# Verilator build and run of the clock-control testbench

VERILATOR ?= verilator
TOP ?= ccu_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ccu_checker.sv
`timescale 1ns/1ns

module ccu_checker #(
   parameter int num_clusters = 4,
   parameter int sync_stages = 2,
   parameter int reset_hold = 8
) (
   input logic gclk,
   input logic rst,
   input logic [ccu_regs_pkg::APB_AW-1:0] paddr,
   input logic psel,
   input logic penable,
   input logic pwrite,
   input logic [ccu_regs_pkg::APB_DW-1:0] pwdata,
   input logic [ccu_regs_pkg::APB_DW-1:0] prdata,
   input logic pready,
   input logic pslverr,
   input logic [num_clusters-1:0] rclk_en,
   input logic [num_clusters-1:0] cluster_grst_l,
   input logic [num_clusters-1:0] dbginit_l,
   output int error_count
);

   // Register model
   logic [num_clusters-1:0] cken_m;
   logic dbg_m;
   logic req_m;
   // Sequencer model, counting the low cycles still ahead
   logic grst_m;
   int hold_left;
   // Delay lines that stand for the header chains, last entry is the output
   logic [num_clusters-1:0] cken_line [sync_stages];
   logic grst_line [sync_stages];
   logic dbginit_line [sync_stages];
   // Comparing starts once the first reset edge has defined the DUT state
   logic armed = 1'b0;
   int errors = 0;
   logic access;
   logic mapped;

   assign error_count = errors;
   assign access = psel & penable;
   assign mapped = (paddr == ccu_regs_pkg::ADDR_CKEN) || (paddr == ccu_regs_pkg::ADDR_DBG) ||
                   (paddr == ccu_regs_pkg::ADDR_RST_REQ) ||
                   (paddr == ccu_regs_pkg::ADDR_STATUS);

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
      if (got !== expected) begin
         $display("FAILED %0t: %s is %h, expected %h", $time, what, got, expected);
         errors++;
      end
   endtask

   // The model advances on the rising edge from the values it held before it
   always @(posedge gclk) begin
      if (rst) begin
         for (int i = 0; i < sync_stages; i++) begin
            cken_line[i] = '0;
            grst_line[i] = 1'b0;
            dbginit_line[i] = 1'b0;
         end
         cken_m = ccu_regs_pkg::CKEN_RESET[num_clusters-1:0];
         dbg_m = 1'b0;
         req_m = 1'b0;
         grst_m = 1'b0;
         hold_left = reset_hold;
         armed = 1'b1;
      end else begin
         // Chains shift first, fed by the register and sequencer state
         for (int i = sync_stages - 1; i > 0; i--) begin
            cken_line[i] = cken_line[i-1];
            grst_line[i] = grst_line[i-1];
            dbginit_line[i] = dbginit_line[i-1];
         end
         cken_line[0] = cken_m;
         grst_line[0] = grst_m;
         dbginit_line[0] = ~dbg_m;
         // A pending request pulls the global reset low for a fresh hold
         if (req_m) begin
            hold_left = reset_hold;
            grst_m = 1'b0;
         end else begin
            if (hold_left > 0) begin
               hold_left--;
            end
            if (hold_left == 0) begin
               grst_m = 1'b1;
            end
         end
         req_m = access && pwrite && (paddr == ccu_regs_pkg::ADDR_RST_REQ) && pwdata[0];
         if (access && pwrite && (paddr == ccu_regs_pkg::ADDR_CKEN)) begin
            cken_m = pwdata[num_clusters-1:0];
         end
         if (access && pwrite && (paddr == ccu_regs_pkg::ADDR_DBG)) begin
            dbg_m = pwdata[0];
         end
      end
   end

   // Outputs are compared mid-cycle, where flops and bus inputs have settled
   always @(negedge gclk) begin
      logic [31:0] exp_rdata;
      if (armed) begin
         compare_value("pready", 32'(pready), 32'(access));
         compare_value("pslverr", 32'(pslverr), 32'(access && !mapped));
         compare_value("rclk_en", 32'(rclk_en), 32'(cken_line[sync_stages-1]));
         compare_value("cluster_grst_l", 32'(cluster_grst_l),
                       32'({num_clusters{grst_line[sync_stages-1]}}));
         compare_value("dbginit_l", 32'(dbginit_l),
                       32'({num_clusters{dbginit_line[sync_stages-1]}}));
         if (access && !pwrite) begin
            exp_rdata = '0;
            // RST_REQ and unmapped addresses read as zero
            if (paddr == ccu_regs_pkg::ADDR_CKEN) begin
               exp_rdata[num_clusters-1:0] = cken_m;
            end else if (paddr == ccu_regs_pkg::ADDR_DBG) begin
               exp_rdata[0] = dbg_m;
            end else if (paddr == ccu_regs_pkg::ADDR_STATUS) begin
               exp_rdata[num_clusters-1:0] = cken_line[sync_stages-1];
               exp_rdata[8] = grst_m;
            end
            compare_value($sformatf("prdata at %h", paddr), prdata, exp_rdata);
         end
      end
   end

endmodule

//--- dv/ccu_tb.sv
`timescale 1ns/1ns

module ccu_tb;

   localparam int num_clusters = 4;
   localparam int sync_stages = 2;
   localparam int reset_hold = 8;
   // Test lengths
   localparam int n_cken_writes = 12;
   localparam int n_dbg_writes = 6;
   localparam int n_bad_accesses = 16;
   localparam int poll_limit = 32;
   // Longest wait for an output, enough for a restarted reset plus the chain
   localparam int wait_limit = 3 * reset_hold + sync_stages + 4;
   localparam int n_transfers = poll_limit + 2 * n_cken_writes + 2 * n_dbg_writes +
                                n_bad_accesses + 8;
   // Two bus cycles plus up to three idle ones per transfer
   localparam int cycles_per_transfer = 6;
   localparam int margin_cycles = (n_cken_writes + n_dbg_writes + 4) * wait_limit + 64;
   localparam int timeout_ns = (n_transfers * cycles_per_transfer + margin_cycles) * 10;

   logic gclk = 1'b0;
   logic rst;
   logic [ccu_regs_pkg::APB_AW-1:0] paddr;
   logic psel;
   logic penable;
   logic pwrite;
   logic [ccu_regs_pkg::APB_DW-1:0] pwdata;
   logic [ccu_regs_pkg::APB_DW-1:0] prdata;
   logic pready;
   logic pslverr;
   logic [num_clusters-1:0] rclk_en;
   logic [num_clusters-1:0] cluster_grst_l;
   logic [num_clusters-1:0] dbginit_l;
   int check_errors;
   int tb_errors = 0;
   int tests_failed = 0;
   int errors_before = 0;
   logic [31:0] rng;
   logic [31:0] rdata;
   logic [7:0] addr;
   int polls;

   always #5 gclk = ~gclk;

   clock_control_top #(
      .num_clusters(num_clusters),
      .sync_stages(sync_stages),
      .reset_hold(reset_hold)
   ) u_clock_control_top (
      .gclk(gclk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .rclk_en(rclk_en), .cluster_grst_l(cluster_grst_l),
      .dbginit_l(dbginit_l)
   );

   ccu_checker #(
      .num_clusters(num_clusters),
      .sync_stages(sync_stages),
      .reset_hold(reset_hold)
   ) u_ccu_checker (
      .gclk(gclk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
      .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .rclk_en(rclk_en), .cluster_grst_l(cluster_grst_l),
      .dbginit_l(dbginit_l), .error_count(check_errors)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // Bus tasks start and end 1 ns after a rising edge
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge gclk);
         #1;
      end
   endtask

   task automatic apb_write(input logic [7:0] a, input logic [31:0] data);
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = a;
      pwdata = data;
      @(posedge gclk);
      #1 penable = 1'b1;
      @(posedge gclk);
      #1 psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] a, output logic [31:0] data);
      psel = 1'b1;
      pwrite = 1'b0;
      paddr = a;
      @(posedge gclk);
      #1 penable = 1'b1;
      // Read data is taken mid access cycle
      @(negedge gclk);
      data = prdata;
      @(posedge gclk);
      #1 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic random_gap();
      rng = xorshift(rng);
      idle_cycles(rng % 4);
   endtask

   function automatic logic [num_clusters-1:0] output_vector(input int which);
      case (which)
         0: return rclk_en;
         1: return cluster_grst_l;
         default: return dbginit_l;
      endcase
   endfunction

   // Waits until the chosen output vector reaches its target, or gives up
   task automatic wait_for_outputs(input int which, input logic [num_clusters-1:0] target);
      int cycles;
      cycles = 0;
      while (output_vector(which) !== target && cycles < wait_limit) begin
         @(posedge gclk);
         #1 cycles++;
      end
      if (output_vector(which) !== target) begin
         $display("Output vector %0d did not reach %b within %0d cycles", which, target,
                  wait_limit);
         tb_errors++;
      end
   endtask

   task automatic finish_test(input int num, input string name);
      int n;
      n = check_errors + tb_errors - errors_before;
      if (n != 0) begin
         tests_failed++;
      end
      $display("test %0d %s: %0d errors", num, name, n);
      errors_before = check_errors + tb_errors;
   endtask

   initial begin
      rst = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      rng = 32'd74911;
      repeat (2) @(posedge gclk);
      #1 rst = 1'b0;

      // Global reset release seen in STATUS, then in every cluster
      polls = 0;
      rdata = '0;
      while (!rdata[8] && polls < poll_limit) begin
         apb_read(ccu_regs_pkg::ADDR_STATUS, rdata);
         polls++;
      end
      if (!rdata[8]) begin
         $display("grst_l was never released after reset");
         tb_errors++;
      end
      wait_for_outputs(1, '1);
      wait_for_outputs(0, ccu_regs_pkg::CKEN_RESET[num_clusters-1:0]);
      finish_test(1, "reset release");

      for (int i = 0; i < n_cken_writes; i++) begin
         rng = xorshift(rng);
         apb_write(ccu_regs_pkg::ADDR_CKEN, rng);
         wait_for_outputs(0, rng[num_clusters-1:0]);
         apb_read(ccu_regs_pkg::ADDR_CKEN, rdata);
         random_gap();
      end
      finish_test(2, "clock enable writes");

      // Level alternates, so the count ends with debug-init released
      for (int i = 0; i < n_dbg_writes; i++) begin
         rng = xorshift(rng);
         apb_write(ccu_regs_pkg::ADDR_DBG, {rng[31:1], ~i[0]});
         wait_for_outputs(2, {num_clusters{i[0]}});
         apb_read(ccu_regs_pkg::ADDR_DBG, rdata);
         random_gap();
      end
      finish_test(3, "debug-init writes");

      // The second request lands while the first hold is still counting
      apb_write(ccu_regs_pkg::ADDR_RST_REQ, 32'h1);
      wait_for_outputs(1, '0);
      idle_cycles(1);
      apb_write(ccu_regs_pkg::ADDR_RST_REQ, 32'h1);
      wait_for_outputs(1, '1);
      apb_read(ccu_regs_pkg::ADDR_RST_REQ, rdata);
      finish_test(4, "reset requests");

      for (int i = 0; i < n_bad_accesses; i++) begin
         rng = xorshift(rng);
         addr = rng[7:0];
         // Mapped addresses move to an unmapped word
         if (addr == 8'h00 || addr == 8'h04 || addr == 8'h08 || addr == 8'h0C) begin
            addr ^= 8'h10;
         end
         rng = xorshift(rng);
         if (rng[0]) begin
            apb_write(addr, rng);
         end else begin
            apb_read(addr, rdata);
         end
         random_gap();
      end
      rng = xorshift(rng);
      apb_write(ccu_regs_pkg::ADDR_STATUS, rng);
      apb_read(ccu_regs_pkg::ADDR_CKEN, rdata);
      apb_read(ccu_regs_pkg::ADDR_DBG, rdata);
      apb_read(ccu_regs_pkg::ADDR_STATUS, rdata);
      finish_test(5, "unmapped accesses");

      $display("tests run: 5, tests failed: %0d, errors: %0d", tests_failed,
               check_errors + tb_errors);
      if (check_errors + tb_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog sized from the test lengths above
   initial begin
      #(timeout_ns);
      $display("Run timed out: the tests did not finish within %0d ns", timeout_ns);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- filelist.f
source/ccu_types_pkg.sv
source/ccu_regs_pkg.sv
source/signal_synchronizer.sv
source/cluster_header.sv
source/reset_sequencer.sv
source/ccu_apb_regs.sv
source/clock_control_top.sv
dv/ccu_checker.sv
dv/ccu_tb.sv

//--- source/ccu_apb_regs.sv
`timescale 1ns/1ns

module ccu_apb_regs #(
   parameter int num_clusters = 4
) (
   input logic gclk,
   input logic rst,
   input logic [ccu_regs_pkg::APB_AW-1:0] paddr,
   input logic psel,
   input logic penable,
   input logic pwrite,
   input logic [ccu_regs_pkg::APB_DW-1:0] pwdata,
   output logic [ccu_regs_pkg::APB_DW-1:0] prdata,
   output logic pready,
   output logic pslverr,
   input logic [num_clusters-1:0] rclk_en_status,
   input logic grst_status,
   output logic [num_clusters-1:0] cken_mask,
   output logic dbg_req,
   output logic rst_req
);

   // Access phase of an APB transfer
   logic access;
   // Address falls inside the register map
   logic addr_hit;
   // Write strobe, valid on the edge that closes the access phase
   logic wr_en;
   // Read data before it reaches the bus
   logic [ccu_regs_pkg::APB_DW-1:0] rdata;

   assign access = psel & penable;
   assign wr_en = access & pwrite & addr_hit;

   // STATUS decodes as mapped even though writes to it are dropped
   assign addr_hit = (paddr == ccu_regs_pkg::ADDR_CKEN) ||
                     (paddr == ccu_regs_pkg::ADDR_DBG) ||
                     (paddr == ccu_regs_pkg::ADDR_RST_REQ) ||
                     (paddr == ccu_regs_pkg::ADDR_STATUS);

   // Zero wait states; pready only rises in the access phase
   assign pready = access;
   assign pslverr = access & ~addr_hit;

   // Writable state: the enable mask and the debug-init level
   always_ff @(posedge gclk) begin
      if (rst) begin
         cken_mask <= ccu_regs_pkg::CKEN_RESET[num_clusters-1:0];
         dbg_req <= ccu_regs_pkg::DBG_RESET;
      end else if (wr_en) begin
         if (paddr == ccu_regs_pkg::ADDR_CKEN) begin
            cken_mask <= pwdata[num_clusters-1:0];
         end
         if (paddr == ccu_regs_pkg::ADDR_DBG) begin
            dbg_req <= pwdata[ccu_regs_pkg::DBG_BIT];
         end
      end
   end

   // Self-clearing request: high for the one cycle after the write edge
   always_ff @(posedge gclk) begin
      if (rst) begin
         rst_req <= 1'b0;
      end else begin
         rst_req <= wr_en && (paddr == ccu_regs_pkg::ADDR_RST_REQ) &&
                    pwdata[ccu_regs_pkg::RST_REQ_BIT];
      end
   end

   // Read mux, unused bits read as zero
   always_comb begin
      rdata = '0;
      case (paddr)
         ccu_regs_pkg::ADDR_CKEN: rdata[num_clusters-1:0] = cken_mask;
         ccu_regs_pkg::ADDR_DBG: rdata[ccu_regs_pkg::DBG_BIT] = dbg_req;
         ccu_regs_pkg::ADDR_STATUS: begin
            rdata[num_clusters-1:0] = rclk_en_status;
            rdata[ccu_regs_pkg::STATUS_GRST_BIT] = grst_status;
         end
         // RST_REQ and unmapped addresses read as zero
         default: rdata = '0;
      endcase
   end

   assign prdata = rdata;

   // Status bits for the clusters must stay below the grst_l bit
   if (num_clusters < 1 || num_clusters > ccu_types_pkg::MAX_CLUSTERS) begin : g_count_check
      $error("num_clusters must be in 1..%0d", ccu_types_pkg::MAX_CLUSTERS);
   end

   // A ready must close a transfer that had its setup phase
   a_pready_phase: assert property (@(posedge gclk) disable iff (rst)
      pready |-> psel && penable && $past(psel))
      else $error("pready outside an APB access phase");

   // Back-to-back access phases cannot happen, so neither can a long request
   a_req_pulse: assert property (@(posedge gclk) disable iff (rst) rst_req |=> !rst_req)
      else $error("rst_req held for more than one cycle");

endmodule

//--- source/ccu_regs_pkg.sv
package ccu_regs_pkg;

   // APB address and data widths
   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   // Register addresses, word aligned
   localparam logic [APB_AW-1:0] ADDR_CKEN = 8'h00;
   localparam logic [APB_AW-1:0] ADDR_DBG = 8'h04;
   localparam logic [APB_AW-1:0] ADDR_RST_REQ = 8'h08;
   localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h0C;

   // Bit positions of the single-bit fields
   localparam int DBG_BIT = 0;
   localparam int RST_REQ_BIT = 0;
   // The rclk_en status bits sit below this one
   localparam int STATUS_GRST_BIT = 8;

   // Every cluster clock is enabled when reset ends
   localparam logic [ccu_types_pkg::MAX_CLUSTERS-1:0] CKEN_RESET = '1;

   // Debug-init request is inactive out of reset
   localparam logic DBG_RESET = 1'b0;

endpackage

//--- source/ccu_types_pkg.sv
package ccu_types_pkg;

   // Largest cluster count the register map can describe
   // CKEN and STATUS reserve one bit per cluster up to this bound
   localparam int MAX_CLUSTERS = 8;

   // A synchronizer needs two flops at least to settle a changing input
   localparam int MIN_SYNC_STAGES = 2;

   // Control payload repeated into each cluster
   // Both fields are active low, so an all-zero value holds the cluster
   // in reset with debug-init asserted
   typedef struct packed {
      // Global reset seen by the cluster
      logic grst_l;
      // Debug-init level seen by the cluster
      logic dbginit_l;
   } cluster_ctl_t;

endpackage

//--- source/clock_control_top.sv
`timescale 1ns/1ns

module clock_control_top #(
   parameter int num_clusters = 4,
   parameter int sync_stages = 2,
   parameter int reset_hold = 8
) (
   input logic gclk,
   input logic rst,
   input logic [ccu_regs_pkg::APB_AW-1:0] paddr,
   input logic psel,
   input logic penable,
   input logic pwrite,
   input logic [ccu_regs_pkg::APB_DW-1:0] pwdata,
   output logic [ccu_regs_pkg::APB_DW-1:0] prdata,
   output logic pready,
   output logic pslverr,
   output logic [num_clusters-1:0] rclk_en,
   output logic [num_clusters-1:0] cluster_grst_l,
   output logic [num_clusters-1:0] dbginit_l
);

   // Register outputs
   logic [num_clusters-1:0] cken_mask;
   logic dbg_req;
   logic rst_req;
   // Global reset from the sequencer
   logic grst_l;
   // Payload shared by every header; debug-init is active low downstream
   ccu_types_pkg::cluster_ctl_t ctl;

   assign ctl = '{grst_l: grst_l, dbginit_l: ~dbg_req};

   // Software view: enables, debug-init and the reset request
   ccu_apb_regs #(
      .num_clusters(num_clusters)
   ) u_ccu_apb_regs (
      .gclk(gclk),
      .rst(rst),
      .paddr(paddr),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr),
      .rclk_en_status(rclk_en),
      .grst_status(grst_l),
      .cken_mask(cken_mask),
      .dbg_req(dbg_req),
      .rst_req(rst_req)
   );

   reset_sequencer #(
      .reset_hold(reset_hold)
   ) u_reset_sequencer (
      .gclk(gclk),
      .rst(rst),
      .rst_req(rst_req),
      .grst_l(grst_l)
   );

   // One header per cluster, each with its own enable bit
   for (genvar i = 0; i < num_clusters; i++) begin : g_cluster
      cluster_header #(
         .sync_stages(sync_stages)
      ) u_cluster_header (
         .gclk(gclk),
         .rst(rst),
         .cluster_cken(cken_mask[i]),
         .ctl_in(ctl),
         .rclk_en(rclk_en[i]),
         .cluster_grst_l(cluster_grst_l[i]),
         .dbginit_l(dbginit_l[i])
      );
   end

endmodule

//--- source/cluster_header.sv
`timescale 1ns/1ns

module cluster_header #(
   parameter int sync_stages = 2
) (
   input logic gclk,
   input logic rst,
   input logic cluster_cken,
   input ccu_types_pkg::cluster_ctl_t ctl_in,
   output logic rclk_en,
   output logic cluster_grst_l,
   output logic dbginit_l
);

   // Reset and debug-init are both held asserted while the chain fills
   localparam ccu_types_pkg::cluster_ctl_t ctl_reset = '{grst_l: 1'b0, dbginit_l: 1'b0};

   // Synchronized copy of the control pair
   ccu_types_pkg::cluster_ctl_t ctl_sync;

   // A shorter chain would not settle a change in the cluster domain
   if (sync_stages < ccu_types_pkg::MIN_SYNC_STAGES) begin : g_stage_check
      $error("cluster_header needs at least %0d sync stages",
             ccu_types_pkg::MIN_SYNC_STAGES);
   end

   // Clock enable for the cluster flops
   // The cluster clock stays off until the enable has crossed the chain
   signal_synchronizer #(
      .payload_t(logic),
      .stages(sync_stages),
      .reset_value(1'b0)
   ) u_cken_sync (
      .gclk(gclk),
      .rst(rst),
      .async_in(cluster_cken),
      .sync_out(rclk_en)
   );

   // Reset and debug-init repeater, both bits travel through the same chain
   // so they stay aligned cycle for cycle
   signal_synchronizer #(
      .payload_t(ccu_types_pkg::cluster_ctl_t),
      .stages(sync_stages),
      .reset_value(ctl_reset)
   ) u_ctl_sync (
      .gclk(gclk),
      .rst(rst),
      .async_in(ctl_in),
      .sync_out(ctl_sync)
   );

   assign cluster_grst_l = ctl_sync.grst_l;
   assign dbginit_l = ctl_sync.dbginit_l;

   // Once reset has had an edge, the cluster sees no clock enable and a held reset
   a_rst_quiet: assert property (@(posedge gclk) $past(rst) |-> !rclk_en && !cluster_grst_l)
      else $error("cluster clock enabled or reset released during rst");

endmodule

//--- source/reset_sequencer.sv
`timescale 1ns/1ns

module reset_sequencer #(
   parameter int reset_hold = 8
) (
   input logic gclk,
   input logic rst,
   input logic rst_req,
   output logic grst_l
);

   // Wide enough for the full hold count
   localparam int cnt_w = $clog2(reset_hold + 1);

   // Cycles left before the global reset releases
   logic [cnt_w-1:0] hold_cnt;

   // The counter loads hold minus one because the release edge itself
   // ends the last low cycle
   always_ff @(posedge gclk) begin
      if (rst) begin
         hold_cnt <= cnt_w'(reset_hold - 1);
         grst_l <= 1'b0;
      end else if (rst_req) begin
         // A new request restarts the count even mid-sequence
         hold_cnt <= cnt_w'(reset_hold - 1);
         grst_l <= 1'b0;
      end else if (hold_cnt != '0) begin
         hold_cnt <= hold_cnt - 1'b1;
      end else begin
         grst_l <= 1'b1;
      end
   end

   // A zero hold would leave nothing to count
   if (reset_hold < 1) begin : g_hold_check
      $error("reset_sequencer needs a hold of at least one cycle");
   end

   // Reset must keep the global reset low for the full hold afterwards
   a_hold_low: assert property (@(posedge gclk) rst |=> !grst_l [*reset_hold])
      else $error("grst_l released before the hold time after rst");

endmodule

//--- source/signal_synchronizer.sv
`timescale 1ns/1ns

module signal_synchronizer #(
   parameter type payload_t = logic,
   parameter int stages = 2,
   parameter payload_t reset_value = '0
) (
   input logic gclk,
   input logic rst,
   input payload_t async_in,
   output payload_t sync_out
);

   // One register per stage; stage 0 captures the input
   payload_t stage_q [stages];

   // Every stage loads the reset value, so the output is defined one
   // edge into reset, long before the chain has filled
   always_ff @(posedge gclk) begin
      if (rst) begin
         for (int i = 0; i < stages; i++) begin
            stage_q[i] <= reset_value;
         end
      end else begin
         stage_q[0] <= async_in;
         // Shift the rest of the chain by one position per edge
         for (int i = 1; i < stages; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   // Output is the last stage, so a change takes exactly stages edges
   assign sync_out = stage_q[stages-1];

   // The whole chain must be flushed to the reset value after one edge
   a_reset_flush: assert property (@(posedge gclk) rst |=> sync_out == reset_value)
      else $error("synchronizer output not at reset value after rst");

endmodule
